/* design/ooo_macros.svh */
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// Datapath and architectural state
`define XLEN        32
`define NUM_REGS    32

// Reservation station split, ALU entries take the low indices
`define NUM_ALU_RS  3
`define NUM_MUL_RS  2
`define NUM_RS      (`NUM_ALU_RS + `NUM_MUL_RS)

// Operand already present in the register file
`define NULL_TAG    3'd7

`endif

/* design/isa_pkg.sv */
package isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;
    localparam logic [6:0] F7_MUL  = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_format_t;

    // One instruction word seen through either format
    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_u;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL
    } alu_op_e;

endpackage

/* design/ooo_pkg.sv */
`include "ooo_macros.svh"

package ooo_pkg;

    // Entry index of the producer, or NULL_TAG
    typedef logic [2:0] rs_tag_t;

    typedef enum logic {
        UNIT_ALU,
        UNIT_MUL
    } unit_class_e;

    // One reservation station slot
    typedef struct packed {
        logic             busy;
        logic             issued;
        isa_pkg::alu_op_e op;
        rs_tag_t          tag_a;
        rs_tag_t          tag_b;
        logic [`XLEN-1:0] val_a;
        logic [`XLEN-1:0] val_b;
        logic [4:0]       dest;
    } rs_entry_t;

    // Operation handed to a functional unit
    typedef struct packed {
        rs_tag_t          tag;
        isa_pkg::alu_op_e op;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [4:0]       dest;
    } issue_t;

endpackage

/* design/ooo_ifs.sv */
`timescale 1ns/1ps
`include "ooo_macros.svh"

// Result broadcast, one per cycle at most
interface cdb_if;
    import ooo_pkg::*;

    logic             valid;
    rs_tag_t          tag;
    logic [`XLEN-1:0] value;
    logic [4:0]       dest;

    modport producer (output valid, tag, value, dest);
    modport consumer (input valid, tag, value, dest);
endinterface

// Entry write from the dispatch controller
interface dispatch_if;
    import isa_pkg::*;
    import ooo_pkg::*;

    logic               valid;
    rs_tag_t            alloc_tag;
    alu_op_e            op;
    rs_tag_t            tag_a;
    rs_tag_t            tag_b;
    logic [`XLEN-1:0]   val_a;
    logic [`XLEN-1:0]   val_b;
    logic [4:0]         dest;
    logic [`NUM_RS-1:0] busy_mask;

    modport sender (output valid, alloc_tag, op, tag_a, tag_b, val_a, val_b, dest,
                    input busy_mask);
    modport receiver (input valid, alloc_tag, op, tag_a, tag_b, val_a, val_b, dest,
                      output busy_mask);
endinterface

// Issue from the station to the ALU and multiplier
interface issue_if;
    import ooo_pkg::*;

    logic   alu_valid;
    issue_t alu_payload;
    logic   mul_valid;
    issue_t mul_payload;
    logic   alu_block;

    modport station (output alu_valid, alu_payload, mul_valid, mul_payload, input alu_block);
    modport units (input alu_valid, alu_payload, mul_valid, mul_payload, output alu_block);
endinterface

/* design/dispatch_ctrl.sv */
`timescale 1ns/1ps
`include "ooo_macros.svh"

module dispatch_ctrl (
    input  logic             clock,
    input  logic             reset,
    input  logic             instr_valid,
    input  isa_pkg::instr_u  instr,
    output logic             drop,
    output logic [4:0]       src_a_idx,
    output logic [4:0]       src_b_idx,
    input  ooo_pkg::rs_tag_t src_a_tag,
    input  ooo_pkg::rs_tag_t src_b_tag,
    input  logic [`XLEN-1:0] src_a_val,
    input  logic [`XLEN-1:0] src_b_val,
    output logic             rename_valid,
    output logic [4:0]       rename_idx,
    output ooo_pkg::rs_tag_t rename_tag,
    dispatch_if.sender       disp
);
    import isa_pkg::*;
    import ooo_pkg::*;

    logic        known;
    logic        use_imm;
    alu_op_e     op;
    unit_class_e cls;
    logic        free_found;
    rs_tag_t     free_tag;
    logic        fire;

    // Register fields come from the R view, the immediate from the I view
    always_comb begin
        known   = 1'b0;
        use_imm = 1'b0;
        op      = OP_ADD;
        if (instr.r.opcode == OPC_OP) begin
            if (instr.r.funct7 == F7_BASE) begin
                known = 1'b1;
                case (instr.r.funct3)
                    F3_ADD_SUB: op = OP_ADD;
                    F3_XOR:     op = OP_XOR;
                    F3_OR:      op = OP_OR;
                    F3_AND:     op = OP_AND;
                    default:    known = 1'b0;
                endcase
            end else if (instr.r.funct7 == F7_SUB && instr.r.funct3 == F3_ADD_SUB) begin
                known = 1'b1;
                op    = OP_SUB;
            end else if (instr.r.funct7 == F7_MUL && instr.r.funct3 == F3_ADD_SUB) begin
                known = 1'b1;
                op    = OP_MUL;
            end
        end else if (instr.i.opcode == OPC_OP_IMM && instr.i.funct3 == F3_ADD_SUB) begin
            known   = 1'b1;
            use_imm = 1'b1;
        end
    end

    assign cls = (op == OP_MUL) ? UNIT_MUL : UNIT_ALU;

    // Lowest free index inside the class's range
    always_comb begin
        free_found = 1'b0;
        free_tag   = `NULL_TAG;
        for (int i = `NUM_RS - 1; i >= 0; i--) begin
            if (!disp.busy_mask[i] && ((i >= `NUM_ALU_RS) == (cls == UNIT_MUL))) begin
                free_found = 1'b1;
                free_tag   = rs_tag_t'(i);
            end
        end
    end

    assign fire = instr_valid && known && free_found;

    assign src_a_idx = instr.r.rs1;
    assign src_b_idx = instr.r.rs2;

    assign disp.valid     = fire;
    assign disp.alloc_tag = free_tag;
    assign disp.op        = op;
    assign disp.dest      = instr.r.rd;

    // x0 is always ready and reads as zero
    assign disp.tag_a = (instr.r.rs1 == 5'd0) ? `NULL_TAG : src_a_tag;
    assign disp.val_a = (instr.r.rs1 == 5'd0) ? '0 : src_a_val;

    always_comb begin
        if (use_imm) begin
            disp.tag_b = `NULL_TAG;
            disp.val_b = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
        end else if (instr.r.rs2 == 5'd0) begin
            disp.tag_b = `NULL_TAG;
            disp.val_b = '0;
        end else begin
            disp.tag_b = src_b_tag;
            disp.val_b = src_b_val;
        end
    end

    assign rename_valid = fire && (instr.r.rd != 5'd0);
    assign rename_idx   = instr.r.rd;
    assign rename_tag   = free_tag;

    // Known op with its class full
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            drop <= 1'b0;
        end else begin
            drop <= instr_valid && known && !free_found;
        end
    end

endmodule

/* design/reg_status.sv */
`timescale 1ns/1ps
`include "ooo_macros.svh"

module reg_status (
    input  logic             clock,
    input  logic             reset,
    input  logic [4:0]       src_a_idx,
    input  logic [4:0]       src_b_idx,
    output ooo_pkg::rs_tag_t src_a_tag,
    output ooo_pkg::rs_tag_t src_b_tag,
    output logic [`XLEN-1:0] src_a_val,
    output logic [`XLEN-1:0] src_b_val,
    input  logic             rename_valid,
    input  logic [4:0]       rename_idx,
    input  ooo_pkg::rs_tag_t rename_tag,
    cdb_if.consumer          cdb,
    input  logic [4:0]       dbg_addr,
    output logic [`XLEN-1:0] dbg_data
);
    import ooo_pkg::*;

    logic [`XLEN-1:0] regs [`NUM_REGS];
    rs_tag_t          map  [`NUM_REGS];
    logic             commit;
    logic             hit_a;
    logic             hit_b;

    // Only the latest producer of a register may retire into it
    assign commit = cdb.valid && (map[cdb.dest] == cdb.tag);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
                map[i]  <= `NULL_TAG;
            end
        end else begin
            if (commit) begin
                regs[cdb.dest] <= cdb.value;
                map[cdb.dest]  <= `NULL_TAG;
            end
            // New producer overrides a same-cycle clear
            if (rename_valid) begin
                map[rename_idx] <= rename_tag;
            end
        end
    end

    // Source reads see a broadcast in the same cycle
    assign hit_a = cdb.valid && (map[src_a_idx] == cdb.tag);
    assign hit_b = cdb.valid && (map[src_b_idx] == cdb.tag);

    assign src_a_tag = hit_a ? `NULL_TAG : map[src_a_idx];
    assign src_a_val = hit_a ? cdb.value : regs[src_a_idx];
    assign src_b_tag = hit_b ? `NULL_TAG : map[src_b_idx];
    assign src_b_val = hit_b ? cdb.value : regs[src_b_idx];

    assign dbg_data = regs[dbg_addr];

endmodule

/* design/reservation_station.sv */
`timescale 1ns/1ps
`include "ooo_macros.svh"

module reservation_station (
    input logic          clock,
    input logic          reset,
    dispatch_if.receiver disp,
    cdb_if.consumer      cdb,
    issue_if.station     iss
);
    import ooo_pkg::*;

    rs_entry_t          rs [`NUM_RS];
    logic [`NUM_RS-1:0] ready;
    logic               alu_found;
    logic               mul_found;
    rs_tag_t            alu_sel;
    rs_tag_t            mul_sel;

    function automatic issue_t make_issue(input rs_entry_t e, input rs_tag_t t);
        issue_t p;
        p.tag  = t;
        p.op   = e.op;
        p.a    = e.val_a;
        p.b    = e.val_b;
        p.dest = e.dest;
        return p;
    endfunction

    // Both operands present and not yet sent to a unit
    always_comb begin
        for (int i = 0; i < `NUM_RS; i++) begin
            disp.busy_mask[i] = rs[i].busy;
            ready[i] = rs[i].busy && !rs[i].issued &&
                       (rs[i].tag_a == `NULL_TAG) && (rs[i].tag_b == `NULL_TAG);
        end
    end

    // Lowest ready index per class
    always_comb begin
        alu_found = 1'b0;
        alu_sel   = '0;
        mul_found = 1'b0;
        mul_sel   = rs_tag_t'(`NUM_ALU_RS);
        for (int i = `NUM_ALU_RS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                alu_found = 1'b1;
                alu_sel   = rs_tag_t'(i);
            end
        end
        for (int i = `NUM_RS - 1; i >= `NUM_ALU_RS; i--) begin
            if (ready[i]) begin
                mul_found = 1'b1;
                mul_sel   = rs_tag_t'(i);
            end
        end
    end

    // ALU waits while the multiplier claims the next CDB slot
    assign iss.alu_valid   = alu_found && !iss.alu_block;
    assign iss.alu_payload = make_issue(rs[alu_sel], alu_sel);
    assign iss.mul_valid   = mul_found;
    assign iss.mul_payload = make_issue(rs[mul_sel], mul_sel);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NUM_RS; i++) begin
                rs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_RS; i++) begin
                if (rs[i].busy && cdb.valid) begin
                    // Own result on the bus frees the slot
                    if (cdb.tag == rs_tag_t'(i)) begin
                        rs[i].busy <= 1'b0;
                    end
                    if (rs[i].tag_a == cdb.tag) begin
                        rs[i].tag_a <= `NULL_TAG;
                        rs[i].val_a <= cdb.value;
                    end
                    if (rs[i].tag_b == cdb.tag) begin
                        rs[i].tag_b <= `NULL_TAG;
                        rs[i].val_b <= cdb.value;
                    end
                end
            end
            if (iss.alu_valid) begin
                rs[alu_sel].issued <= 1'b1;
            end
            if (iss.mul_valid) begin
                rs[mul_sel].issued <= 1'b1;
            end
            if (disp.valid) begin
                rs[disp.alloc_tag] <= '{busy: 1'b1, issued: 1'b0, op: disp.op,
                                        tag_a: disp.tag_a, tag_b: disp.tag_b,
                                        val_a: disp.val_a, val_b: disp.val_b,
                                        dest: disp.dest};
            end
        end
    end

endmodule

/* design/exec_units.sv */
`timescale 1ns/1ps
`include "ooo_macros.svh"

module exec_units (
    input logic     clock,
    input logic     reset,
    issue_if.units  iss,
    cdb_if.producer cdb
);
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int HALF = `XLEN / 2;

    logic             alu_v;
    rs_tag_t          alu_tag;
    logic [4:0]       alu_dest;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] alu_next;

    // Multiplier stage valids, tags and destinations
    logic [2:0]       mul_v;
    rs_tag_t          mul_tag  [3];
    logic [4:0]       mul_dest [3];

    // Partial products, then cross sum, then final product
    logic [`XLEN-1:0] s1_ll;
    logic [HALF-1:0]  s1_lh;
    logic [HALF-1:0]  s1_hl;
    logic [`XLEN-1:0] s2_ll;
    logic [HALF-1:0]  s2_cross;
    logic [`XLEN-1:0] s3_prod;

    always_comb begin
        case (iss.alu_payload.op)
            OP_SUB:  alu_next = iss.alu_payload.a - iss.alu_payload.b;
            OP_AND:  alu_next = iss.alu_payload.a & iss.alu_payload.b;
            OP_OR:   alu_next = iss.alu_payload.a | iss.alu_payload.b;
            OP_XOR:  alu_next = iss.alu_payload.a ^ iss.alu_payload.b;
            default: alu_next = iss.alu_payload.a + iss.alu_payload.b;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_v <= 1'b0;
            mul_v <= '0;
        end else begin
            alu_v <= iss.alu_valid;
            mul_v <= {mul_v[1:0], iss.mul_valid};
        end
    end

    always_ff @(posedge clock) begin
        alu_tag     <= iss.alu_payload.tag;
        alu_dest    <= iss.alu_payload.dest;
        alu_res     <= alu_next;
        mul_tag[0]  <= iss.mul_payload.tag;
        mul_tag[1]  <= mul_tag[0];
        mul_tag[2]  <= mul_tag[1];
        mul_dest[0] <= iss.mul_payload.dest;
        mul_dest[1] <= mul_dest[0];
        mul_dest[2] <= mul_dest[1];
        s1_ll    <= `XLEN'(iss.mul_payload.a[HALF-1:0]) * `XLEN'(iss.mul_payload.b[HALF-1:0]);
        s1_lh    <= iss.mul_payload.a[HALF-1:0] * iss.mul_payload.b[`XLEN-1:HALF];
        s1_hl    <= iss.mul_payload.a[`XLEN-1:HALF] * iss.mul_payload.b[HALF-1:0];
        s2_ll    <= s1_ll;
        s2_cross <= s1_lh + s1_hl;
        s3_prod  <= s2_ll + {s2_cross, {HALF{1'b0}}};
    end

    // Stage two valid means the multiplier takes the CDB next cycle
    assign iss.alu_block = mul_v[1];

    assign cdb.valid = mul_v[2] || alu_v;
    assign cdb.tag   = mul_v[2] ? mul_tag[2] : alu_tag;
    assign cdb.dest  = mul_v[2] ? mul_dest[2] : alu_dest;
    assign cdb.value = mul_v[2] ? s3_prod : alu_res;

endmodule

/* design/ooo_core_top.sv */
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_core_top (
    input  logic             clock,
    input  logic             reset,
    input  logic             instr_valid,
    input  logic [31:0]      instr,
    output logic             drop,
    output logic             cdb_valid,
    output logic [4:0]       cdb_dest,
    output logic [`XLEN-1:0] cdb_value,
    input  logic [4:0]       dbg_addr,
    output logic [`XLEN-1:0] dbg_data
);
    import ooo_pkg::*;

    // Dispatch to register status
    logic [4:0]       src_a_idx;
    logic [4:0]       src_b_idx;
    rs_tag_t          src_a_tag;
    rs_tag_t          src_b_tag;
    logic [`XLEN-1:0] src_a_val;
    logic [`XLEN-1:0] src_b_val;
    logic             rename_valid;
    logic [4:0]       rename_idx;
    rs_tag_t          rename_tag;

    cdb_if      cdb ();
    dispatch_if disp ();
    issue_if    iss ();

    dispatch_ctrl u_dispatch (
        .clock, .reset, .instr_valid, .instr, .drop,
        .src_a_idx, .src_b_idx, .src_a_tag, .src_b_tag, .src_a_val, .src_b_val,
        .rename_valid, .rename_idx, .rename_tag,
        .disp (disp.sender)
    );

    reg_status u_reg_status (
        .clock, .reset,
        .src_a_idx, .src_b_idx, .src_a_tag, .src_b_tag, .src_a_val, .src_b_val,
        .rename_valid, .rename_idx, .rename_tag,
        .cdb (cdb.consumer),
        .dbg_addr, .dbg_data
    );

    reservation_station u_rs (
        .clock, .reset,
        .disp (disp.receiver),
        .cdb  (cdb.consumer),
        .iss  (iss.station)
    );

    exec_units u_exec (
        .clock, .reset,
        .iss (iss.units),
        .cdb (cdb.producer)
    );

    assign cdb_valid = cdb.valid;
    assign cdb_dest  = cdb.dest;
    assign cdb_value = cdb.value;

endmodule

/* testbench/tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core;
    import isa_pkg::*;

    // Reset and six tests of up to 60 cycles each with margin
    localparam int TIMEOUT_CYCLES = 400;
    localparam int RESULT_WAIT    = 40;
    localparam int SETTLE_CYCLES  = 12;

    // funct7 and funct3 of each R-type operation
    localparam logic [9:0] K_ADD = {7'h00, 3'h0};
    localparam logic [9:0] K_SUB = {7'h20, 3'h0};
    localparam logic [9:0] K_AND = {7'h00, 3'h7};
    localparam logic [9:0] K_OR  = {7'h00, 3'h6};
    localparam logic [9:0] K_XOR = {7'h00, 3'h4};
    localparam logic [9:0] K_MUL = {7'h01, 3'h0};

    logic        clock;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        drop;
    logic        cdb_valid;
    logic [4:0]  cdb_dest;
    logic [31:0] cdb_value;
    logic [4:0]  dbg_addr;
    logic [31:0] dbg_data;

    logic [31:0] model [32];
    logic [4:0]  log_dest [$];
    logic [31:0] log_value [$];
    int          drop_count = 0;
    int          cycle_count = 0;
    integer      seed;

    ooo_core_top DUT (
        .clock, .reset, .instr_valid, .instr, .drop,
        .cdb_valid, .cdb_dest, .cdb_value, .dbg_addr, .dbg_data
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Simulation ran past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    // Mid-cycle snapshot of every broadcast and every drop pulse
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            log_dest.push_back(cdb_dest);
            log_value.push_back(cdb_value);
        end
        if (!reset && drop) begin
            drop_count++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
        instr_valid = 1'b0;
    endtask

    task automatic settle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send_word(input logic [31:0] word);
        @(posedge clock);
        #2;
        instr_valid = 1'b1;
        instr       = word;
    endtask

    function automatic logic [31:0] expected_result(input logic [9:0] kind,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        case (kind)
            K_SUB:   return a - b;
            K_AND:   return a & b;
            K_OR:    return a | b;
            K_XOR:   return a ^ b;
            K_MUL:   return a * b;
            default: return a + b;
        endcase
    endfunction

    // R-type strobe that updates the model in program order when accepted
    task automatic send_r(input logic [9:0] kind, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2, input bit accepted);
        logic [31:0] a;
        logic [31:0] b;
        a = model[rs1];
        b = model[rs2];
        send_word({kind[9:3], rs2, rs1, kind[2:0], rd, OPC_OP});
        if (accepted) begin
            model[rd] = expected_result(kind, a, b);
        end
        model[0] = '0;
    endtask

    task automatic send_i(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] a;
        a = model[rs1];
        send_word({imm, rs1, 3'b000, rd, OPC_OP_IMM});
        model[rd] = a + {{20{imm[11]}}, imm};
        model[0]  = '0;
    endtask

    task automatic clear_log();
        log_dest.delete();
        log_value.delete();
    endtask

    // Finds a broadcast for dest in any order and consumes it
    task automatic wait_result(input logic [4:0] dest);
        int pos;
        int waited;
        int i;
        pos    = -1;
        waited = 0;
        while (pos < 0) begin
            for (i = 0; i < log_dest.size(); i++) begin
                if (pos < 0 && log_dest[i] == dest) begin
                    pos = i;
                end
            end
            if (pos < 0) begin
                if (waited == RESULT_WAIT) begin
                    $display("No CDB broadcast for x%0d after %0d cycles", dest, RESULT_WAIT);
                    $display("test failed");
                    $fatal(1, "result wait expired");
                end else begin
                    next_cycle();
                    waited++;
                end
            end
        end
        check_value($sformatf("cdb_value x%0d", dest), log_value[pos], model[dest]);
        log_dest.delete(pos);
        log_value.delete(pos);
    endtask

    task automatic check_reg(input logic [4:0] idx);
        next_cycle();
        dbg_addr = idx;
        @(negedge clock);
        check_value($sformatf("dbg_data x%0d", idx), dbg_data, model[idx]);
    endtask

    task automatic after_reset();
        check_value("cdb_valid", 32'(cdb_valid), 0);
        check_value("drop", 32'(drop), 0);
        check_reg(31);
    endtask

    task automatic addi_from_x0();
        logic [11:0] imm;
        int          r;
        clear_log();
        for (r = 1; r <= 4; r++) begin
            imm = 12'($random(seed));
            // Last one builds on the previous result
            send_i(5'(r), (r == 4) ? 5'd3 : 5'd0, imm);
            wait_result(5'(r));
            check_reg(5'(r));
        end
    endtask

    task automatic dependent_alu_chain();
        int start;
        int r;
        clear_log();
        start = drop_count;
        send_r(K_ADD, 5, 1, 2, 1);
        send_r(K_SUB, 6, 5, 3, 1);
        send_r(K_XOR, 7, 6, 5, 1);
        send_r(K_AND, 8, 7, 1, 1);
        // All three ALU entries are held here and one frees a cycle later
        next_cycle();
        send_r(K_OR, 9, 8, 6, 1);
        wait_result(9);
        check_value("drop_count", drop_count - start, 0);
        for (r = 5; r <= 9; r++) begin
            check_reg(5'(r));
        end
    endtask

    task automatic mul_with_dependents();
        clear_log();
        send_r(K_MUL, 10, 1, 2, 1);
        send_r(K_ADD, 11, 10, 3, 1);
        send_r(K_ADD, 12, 4, 1, 1);
        wait_result(12);
        wait_result(10);
        wait_result(11);
        check_reg(10);
        check_reg(11);
        check_reg(12);
    endtask

    // Third and fourth multiply strobes find both multiply entries busy
    task automatic mul_class_full();
        int start;
        clear_log();
        start = drop_count;
        send_r(K_MUL, 13, 1, 2, 1);
        send_r(K_MUL, 14, 2, 3, 1);
        send_r(K_MUL, 15, 3, 4, 0);
        send_r(K_MUL, 16, 4, 1, 0);
        wait_result(13);
        wait_result(14);
        settle(SETTLE_CYCLES);
        check_value("extra cdb broadcasts", log_dest.size(), 0);
        check_value("drop_count", drop_count - start, 2);
        check_reg(15);
        check_reg(16);
    endtask

    task automatic x0_write_ignored();
        clear_log();
        send_i(0, 1, 12'($random(seed)));
        send_r(K_ADD, 17, 0, 1, 1);
        wait_result(17);
        settle(SETTLE_CYCLES);
        check_reg(0);
        check_reg(17);
    endtask

    // Older writer is the slower multiplier and loses to the younger ADDI
    task automatic waw_younger_wins();
        int start;
        clear_log();
        start = drop_count;
        send_r(K_MUL, 20, 1, 2, 1);
        send_i(20, 0, 12'($random(seed)));
        send_i(22, 0, 12'($random(seed)));
        send_i(22, 0, 12'($random(seed)));
        settle(SETTLE_CYCLES);
        check_value("drop_count", drop_count - start, 0);
        check_reg(20);
        check_reg(22);
    endtask

    initial begin
        seed        = 32'hb67e9f7c;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        dbg_addr    = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;
        after_reset();
        addi_from_x0();
        dependent_alu_chain();
        mul_with_dependents();
        mul_class_full();
        x0_write_ignored();
        waw_younger_wins();
        $display("test passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+design
design/isa_pkg.sv
design/ooo_pkg.sv
design/ooo_ifs.sv
design/dispatch_ctrl.sv
design/reg_status.sv
design/reservation_station.sv
design/exec_units.sv
design/ooo_core_top.sv
testbench/tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run, the exit status follows the testbench
cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module tb_ooo_core -o tb_ooo_core &&
./obj_dir/tb_ooo_core || { echo "simulation did not complete cleanly"; exit 1; }
